//--- Makefile
VERILATOR ?= verilator
TOP ?= predecoderTb
FILELIST ?= all.f
BUILD_DIR ?= build
LOG ?= $(BUILD_DIR)/sim.log
PASS_TEXT ?= Simulation passed
VFLAGS ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv tests/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+logic
+incdir+tests
logic/riscvIsaPkg.sv
logic/predecodePkg.sv
logic/compressedExpander.sv
logic/baseWordChecker.sv
logic/predecodeStage.sv
logic/instructionPredecoder.sv
tests/predecoderTb.sv

//--- logic/baseWordChecker.sv
`timescale 1ns/1ps

`include "predecode_params.svh"

module baseWordChecker (
  input  logic [`PREDECODE_WORD_WIDTH-1:0] word,
  output predecodePkg::predecodeStatus     wordStatus
);
  import riscvIsaPkg::*;
  import predecodePkg::*;

  baseOpcode opcode;
  logic [2:0] funct3;

  assign opcode = baseOpcode'(word[6:0]);
  assign funct3 = word[14:12];

  always_comb begin
    wordStatus = statusIllegal;
    if (word[4:2] != 3'b111) begin  // 48-bit and longer formats
      case (opcode)
        opLoad: begin
          if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
            wordStatus = statusOk;
          end
        end
        opStore: begin
          if (funct3 <= 3'b010) begin
            wordStatus = statusOk;
          end
        end
        opBranch: begin
          if (funct3 != 3'b010 && funct3 != 3'b011) begin
            wordStatus = statusOk;
          end
        end
        opJalr: begin
          if (funct3 == 3'b000) begin
            wordStatus = statusOk;
          end
        end
        opMiscMem, opOpImm, opAuipc, opOp, opLui, opJal, opSystem: begin
          wordStatus = statusOk;
        end
        default: wordStatus = statusIllegal;
      endcase
    end
  end

endmodule

//--- logic/compressedExpander.sv
`timescale 1ns/1ps

`include "predecode_params.svh"

module compressedExpander (
  input  logic [`PREDECODE_HALF_WIDTH-1:0] halfword,
  output logic [`PREDECODE_WORD_WIDTH-1:0] expandedInstruction,
  output predecodePkg::predecodeStatus     expandedStatus
);
  import riscvIsaPkg::*;
  import predecodePkg::*;

  compressedQuadrant quadrant;
  logic [2:0] funct3;
  logic [4:0] rdFull;
  logic [4:0] rs2Full;
  logic [4:0] rdPrime;   // Also rs2' in stores and arithmetic
  logic [4:0] rs1Prime;
  logic [5:0] shamt;

  logic [11:0] immSmall;  // CI form, sign extended
  logic [9:0] immAddi4spn;
  logic [6:0] immWord;
  logic [11:0] immAddi16sp;
  logic [19:0] immLui;
  logic [20:0] immJump;
  logic [12:0] immBranch;
  logic [7:0] immLwsp;
  logic [7:0] immSwsp;

  logic [`PREDECODE_WORD_WIDTH-1:0] expansion;

  assign quadrant = compressedQuadrant'(halfword[1:0]);
  assign funct3 = halfword[15:13];
  assign rdFull = halfword[11:7];
  assign rs2Full = halfword[6:2];
  assign rdPrime = {2'b01, halfword[4:2]};  // x8..x15
  assign rs1Prime = {2'b01, halfword[9:7]};
  assign shamt = {halfword[12], halfword[6:2]};

  // Unscramble the immediates
  assign immSmall = {{6{halfword[12]}}, halfword[12], halfword[6:2]};
  assign immAddi4spn = {halfword[10:7], halfword[12:11], halfword[5], halfword[6], 2'b00};
  assign immWord = {halfword[5], halfword[12:10], halfword[6], 2'b00};
  assign immAddi16sp = {{3{halfword[12]}}, halfword[4:3], halfword[5], halfword[2],
                        halfword[6], 4'b0000};
  assign immLui = {{15{halfword[12]}}, halfword[6:2]};
  assign immJump = {{10{halfword[12]}}, halfword[8], halfword[10:9], halfword[6], halfword[7],
                    halfword[2], halfword[11], halfword[5:3], 1'b0};
  assign immBranch = {{5{halfword[12]}}, halfword[6:5], halfword[2], halfword[11:10],
                      halfword[4:3], 1'b0};
  assign immLwsp = {halfword[3:2], halfword[12], halfword[6:4], 2'b00};
  assign immSwsp = {halfword[8:7], halfword[12:9], 2'b00};

  always_comb begin
    expansion = '0;
    expandedStatus = statusOk;
    case (quadrant)
      quadrant0: begin
        case (funct3)
          3'b000: begin
            if (immAddi4spn == '0) begin  // Zero halfword lands here too
              expandedStatus = statusIllegal;
            end else begin  // C.ADDI4SPN
              expansion = {2'b00, immAddi4spn, 5'd2, 3'b000, rdPrime, opOpImm};
            end
          end
          3'b010: expansion = {5'b0, immWord, rs1Prime, 3'b010, rdPrime, opLoad};  // C.LW
          3'b110: begin  // C.SW
            expansion = {5'b0, immWord[6:5], rdPrime, rs1Prime, 3'b010, immWord[4:0], opStore};
          end
          3'b100: expandedStatus = statusIllegal;  // Reserved
          default: expandedStatus = statusUnsupported;
        endcase
      end

      quadrant1: begin
        case (funct3)
          3'b000: begin
            if (halfword[12:2] == '0) begin  // C.NOP
              expansion = `PREDECODE_NOP;
            end else begin  // C.ADDI
              expansion = {immSmall, rdFull, 3'b000, rdFull, opOpImm};
            end
          end
          3'b001: begin  // C.JAL
            expansion = {immJump[20], immJump[10:1], immJump[11], immJump[19:12], 5'd1, opJal};
          end
          3'b010: expansion = {immSmall, 5'd0, 3'b000, rdFull, opOpImm};  // C.LI
          3'b011: begin
            if (rdFull == 5'd2) begin
              if (immAddi16sp == '0) begin
                expandedStatus = statusIllegal;
              end else begin  // C.ADDI16SP
                expansion = {immAddi16sp, 5'd2, 3'b000, 5'd2, opOpImm};
              end
            end else if (immLui == '0) begin
              expandedStatus = statusIllegal;
            end else begin  // C.LUI
              expansion = {immLui, rdFull, opLui};
            end
          end
          3'b100: begin
            case (halfword[11:10])
              2'b00: expansion = {6'b000000, shamt, rs1Prime, 3'b101, rs1Prime, opOpImm};  // C.SRLI
              2'b01: expansion = {6'b010000, shamt, rs1Prime, 3'b101, rs1Prime, opOpImm};  // C.SRAI
              2'b10: expansion = {immSmall, rs1Prime, 3'b111, rs1Prime, opOpImm};  // C.ANDI
              default: begin
                case ({halfword[12], halfword[6:5]})
                  3'b000: expansion = {7'b0100000, rdPrime, rs1Prime, 3'b000, rs1Prime, opOp};
                  3'b001: expansion = {7'b0000000, rdPrime, rs1Prime, 3'b100, rs1Prime, opOp};
                  3'b010: expansion = {7'b0000000, rdPrime, rs1Prime, 3'b110, rs1Prime, opOp};
                  3'b011: expansion = {7'b0000000, rdPrime, rs1Prime, 3'b111, rs1Prime, opOp};
                  3'b100, 3'b101: expandedStatus = statusUnsupported;  // C.SUBW, C.ADDW
                  default: expandedStatus = statusIllegal;
                endcase
              end
            endcase
          end
          3'b101: begin  // C.J
            expansion = {immJump[20], immJump[10:1], immJump[11], immJump[19:12], 5'd0, opJal};
          end
          default: begin  // C.BEQZ, C.BNEZ
            expansion = {immBranch[12], immBranch[10:5], 5'd0, rs1Prime, 2'b00, funct3[0],
                         immBranch[4:1], immBranch[11], opBranch};
          end
        endcase
      end

      quadrant2: begin
        case (funct3)
          3'b000: expansion = {6'b000000, shamt, rdFull, 3'b001, rdFull, opOpImm};  // C.SLLI
          3'b010: begin
            if (rdFull == 5'd0) begin
              expandedStatus = statusIllegal;
            end else begin  // C.LWSP
              expansion = {4'b0, immLwsp, 5'd2, 3'b010, rdFull, opLoad};
            end
          end
          3'b100: begin
            if (!halfword[12]) begin
              if (rs2Full != 5'd0) begin  // C.MV
                expansion = {7'b0, rs2Full, 5'd0, 3'b000, rdFull, opOp};
              end else if (rdFull == 5'd0) begin
                expandedStatus = statusIllegal;
              end else begin  // C.JR
                expansion = {12'b0, rdFull, 3'b000, 5'd0, opJalr};
              end
            end else if (rs2Full != 5'd0) begin  // C.ADD
              expansion = {7'b0, rs2Full, rdFull, 3'b000, rdFull, opOp};
            end else if (rdFull == 5'd0) begin  // C.EBREAK
              expansion = {12'd1, 5'd0, 3'b000, 5'd0, opSystem};
            end else begin  // C.JALR
              expansion = {12'b0, rdFull, 3'b000, 5'd1, opJalr};
            end
          end
          3'b110: begin  // C.SWSP
            expansion = {4'b0, immSwsp[7:5], rs2Full, 5'd2, 3'b010, immSwsp[4:0], opStore};
          end
          default: expandedStatus = statusUnsupported;
        endcase
      end

      default: expandedStatus = statusIllegal;  // Not a compressed encoding
    endcase
    okIsFullOpcode: assert (expandedStatus != statusOk || expansion[1:0] == 2'b11)
      else $error("Expansion of %h marked ok without a 32-bit opcode", halfword);
  end

  assign expandedInstruction = (expandedStatus == statusOk) ? expansion : '0;

endmodule

//--- logic/instructionPredecoder.sv
`timescale 1ns/1ps

`include "predecode_params.svh"

module instructionPredecoder (
  input  logic                         clock,
  input  logic                         reset,
  input  predecodePkg::fetchWord       fetch,
  output predecodePkg::predecodeResult result,
  output logic                         decodeValid
);
  import predecodePkg::*;

  logic [`PREDECODE_WORD_WIDTH-1:0] expandedInstruction;
  predecodeStatus expandedStatus;
  predecodeStatus wordStatus;

  // Low half only, length is decided in the stage
  compressedExpander expander_i (
    .halfword            (fetch.word[`PREDECODE_HALF_WIDTH-1:0]),
    .expandedInstruction (expandedInstruction),
    .expandedStatus      (expandedStatus)
  );

  baseWordChecker checker_i (
    .word       (fetch.word),
    .wordStatus (wordStatus)
  );

  predecodeStage stage_i (
    .clock               (clock),
    .reset               (reset),
    .fetch               (fetch),
    .expandedInstruction (expandedInstruction),
    .expandedStatus      (expandedStatus),
    .wordStatus          (wordStatus),
    .result              (result),
    .decodeValid         (decodeValid)
  );

endmodule

//--- logic/predecodePkg.sv
`include "predecode_params.svh"

package predecodePkg;

  typedef enum logic [1:0] {
    statusOk          = 2'b00,
    statusIllegal     = 2'b01,
    statusUnsupported = 2'b10  // FP and RV64/RV128 forms
  } predecodeStatus;

  // From fetch
  typedef struct packed {
    logic [`PREDECODE_WORD_WIDTH-1:0] word;
    logic                             valid;
  } fetchWord;

  // To decode
  typedef struct packed {
    logic [`PREDECODE_WORD_WIDTH-1:0] instruction;
    predecodeStatus                   status;
    logic                             compressed;
  } predecodeResult;

endpackage

//--- logic/predecodeStage.sv
`timescale 1ns/1ps

`include "predecode_params.svh"

module predecodeStage (
  input  logic                             clock,
  input  logic                             reset,
  input  predecodePkg::fetchWord           fetch,
  input  logic [`PREDECODE_WORD_WIDTH-1:0] expandedInstruction,
  input  predecodePkg::predecodeStatus     expandedStatus,
  input  predecodePkg::predecodeStatus     wordStatus,
  output predecodePkg::predecodeResult     result,
  output logic                             decodeValid
);
  import riscvIsaPkg::*;
  import predecodePkg::*;

  compressedQuadrant quadrant;
  logic isCompressed;
  predecodeResult selected;

  assign quadrant = compressedQuadrant'(fetch.word[1:0]);
  assign isCompressed = (quadrant != fullWidth);

  always_comb begin
    selected.compressed = isCompressed;
    if (isCompressed) begin
      selected.status = expandedStatus;
      selected.instruction = expandedInstruction;
    end else begin
      selected.status = wordStatus;
      selected.instruction = fetch.word;  // Passes through as fetched
    end
    if (selected.status != statusOk) begin
      selected.instruction = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
      decodeValid <= 1'b0;
    end else begin
      decodeValid <= fetch.valid;
      if (fetch.valid) begin  // Hold last result while idle
        result <= selected;
      end
    end
  end

  validLowAfterReset: assert property (@(posedge clock) $past(reset) |-> !decodeValid)
    else $error("decodeValid high in the cycle after reset");

  validFollowsFetch: assert property (
    @(posedge clock) disable iff (reset)
    !$past(reset) |-> decodeValid == $past(fetch.valid)
  ) else $error("decodeValid does not trail fetch valid by one cycle");

endmodule

//--- logic/predecode_params.svh
`ifndef PREDECODE_PARAMS_SVH
`define PREDECODE_PARAMS_SVH

// Fetch word and expanded instruction
`define PREDECODE_WORD_WIDTH 32

// Compressed instruction
`define PREDECODE_HALF_WIDTH 16

// ADDI x0, x0, 0
`define PREDECODE_NOP 32'h0000_0013

`endif

//--- logic/riscvIsaPkg.sv
package riscvIsaPkg;

  // RV32I major opcodes, bits 6:0
  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,
    opMiscMem = 7'b0001111,
    opOpImm   = 7'b0010011,
    opAuipc   = 7'b0010111,
    opStore   = 7'b0100011,
    opOp      = 7'b0110011,
    opLui     = 7'b0110111,
    opBranch  = 7'b1100011,
    opJalr    = 7'b1100111,
    opJal     = 7'b1101111,
    opSystem  = 7'b1110011
  } baseOpcode;

  // Low two bits of any instruction
  typedef enum logic [1:0] {
    quadrant0 = 2'b00,
    quadrant1 = 2'b01,
    quadrant2 = 2'b10,
    fullWidth = 2'b11  // Not compressed
  } compressedQuadrant;

endpackage

//--- tests/expandModel.svh
`ifndef EXPAND_MODEL_SVH
`define EXPAND_MODEL_SVH

`include "predecode_params.svh"

function automatic logic [31:0] formatI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] formatS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [6:0] op);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic logic [31:0] formatB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [6:0] op);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
endfunction

function automatic logic [31:0] formatJ(logic [20:0] imm, logic [4:0] rd, logic [6:0] op);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
endfunction

function automatic logic [31:0] formatR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic predecodeResult modelCompressed(logic [15:0] h);
  predecodeResult r;
  logic [4:0] rd;
  logic [4:0] rs2;
  logic [4:0] rdc;  // x8..x15 from bits 4:2
  logic [4:0] rsc;  // x8..x15 from bits 9:7
  logic [11:0] imm6;
  logic [11:0] off;
  logic [20:0] jOff;
  logic [12:0] bOff;
  r.instruction = '0;
  r.status = statusOk;
  r.compressed = 1'b1;
  rd = h[11:7];
  rs2 = h[6:2];
  rdc = {2'b01, h[4:2]};
  rsc = {2'b01, h[9:7]};
  imm6 = {{7{h[12]}}, h[6:2]};
  off = '0;
  jOff = {{10{h[12]}}, 11'b0};
  jOff[4] = h[11];
  jOff[9:8] = h[10:9];
  jOff[10] = h[8];
  jOff[6] = h[7];
  jOff[7] = h[6];
  jOff[3:1] = h[5:3];
  jOff[5] = h[2];
  bOff = {{5{h[12]}}, 8'b0};
  bOff[4:3] = h[11:10];
  bOff[2:1] = h[4:3];
  bOff[7:6] = h[6:5];
  bOff[5] = h[2];
  case ({h[1:0], h[15:13]})
    5'b00_000: begin  // C.ADDI4SPN
      off[5:4] = h[12:11];
      off[9:6] = h[10:7];
      off[2] = h[6];
      off[3] = h[5];
      r.status = (off == '0) ? statusIllegal : statusOk;
      r.instruction = formatI(off, 5'd2, 3'b000, rdc, 7'h13);
    end
    5'b00_010, 5'b00_110: begin
      off[5:3] = h[12:10];
      off[2] = h[6];
      off[6] = h[5];
      if (h[15]) begin
        r.instruction = formatS(off, rdc, rsc, 3'b010, 7'h23);
      end else begin
        r.instruction = formatI(off, rsc, 3'b010, rdc, 7'h03);
      end
    end
    5'b00_100: r.status = statusIllegal;
    5'b01_000: begin
      r.instruction = (h[12:2] == '0) ? `PREDECODE_NOP : formatI(imm6, rd, 3'b000, rd, 7'h13);
    end
    5'b01_001: r.instruction = formatJ(jOff, 5'd1, 7'h6F);
    5'b01_101: r.instruction = formatJ(jOff, 5'd0, 7'h6F);
    5'b01_010: r.instruction = formatI(imm6, 5'd0, 3'b000, rd, 7'h13);
    5'b01_011: begin
      if (rd == 5'd2) begin  // C.ADDI16SP
        off = {{3{h[12]}}, 9'b0};
        off[4] = h[6];
        off[6] = h[5];
        off[8:7] = h[4:3];
        off[5] = h[2];
        r.status = (off == '0) ? statusIllegal : statusOk;
        r.instruction = formatI(off, 5'd2, 3'b000, 5'd2, 7'h13);
      end else begin
        r.status = (imm6 == '0) ? statusIllegal : statusOk;
        r.instruction = {{8{imm6[11]}}, imm6, rd, 7'h37};
      end
    end
    5'b01_100: begin
      case (h[11:10])
        2'b00: r.instruction = formatI({6'b000000, h[12], h[6:2]}, rsc, 3'b101, rsc, 7'h13);
        2'b01: r.instruction = formatI({6'b010000, h[12], h[6:2]}, rsc, 3'b101, rsc, 7'h13);
        2'b10: r.instruction = formatI(imm6, rsc, 3'b111, rsc, 7'h13);
        default: begin
          if (h[12]) begin
            r.status = h[6] ? statusIllegal : statusUnsupported;
          end else begin
            case (h[6:5])
              2'b00: r.instruction = formatR(7'h20, rdc, rsc, 3'b000, rsc, 7'h33);
              2'b01: r.instruction = formatR(7'h00, rdc, rsc, 3'b100, rsc, 7'h33);
              2'b10: r.instruction = formatR(7'h00, rdc, rsc, 3'b110, rsc, 7'h33);
              default: r.instruction = formatR(7'h00, rdc, rsc, 3'b111, rsc, 7'h33);
            endcase
          end
        end
      endcase
    end
    5'b01_110, 5'b01_111: r.instruction = formatB(bOff, 5'd0, rsc, {2'b00, h[13]}, 7'h63);
    5'b10_000: r.instruction = formatI({6'b000000, h[12], h[6:2]}, rd, 3'b001, rd, 7'h13);
    5'b10_010: begin  // C.LWSP
      off[5] = h[12];
      off[4:2] = h[6:4];
      off[7:6] = h[3:2];
      r.status = (rd == 5'd0) ? statusIllegal : statusOk;
      r.instruction = formatI(off, 5'd2, 3'b010, rd, 7'h03);
    end
    5'b10_100: begin
      if (rs2 != 5'd0) begin  // C.MV or C.ADD
        r.instruction = formatR(7'h00, rs2, h[12] ? rd : 5'd0, 3'b000, rd, 7'h33);
      end else if (h[12] && rd == 5'd0) begin
        r.instruction = 32'h0010_0073;  // EBREAK
      end else if (rd == 5'd0) begin
        r.status = statusIllegal;
      end else begin
        r.instruction = formatI(12'd0, rd, 3'b000, {4'b0000, h[12]}, 7'h67);
      end
    end
    5'b10_110: begin  // C.SWSP
      off[5:2] = h[12:9];
      off[7:6] = h[8:7];
      r.instruction = formatS(off, rs2, 5'd2, 3'b010, 7'h23);
    end
    default: r.status = statusUnsupported;  // FP and RV64 slots
  endcase
  if (r.status != statusOk) begin
    r.instruction = '0;
  end
  return r;
endfunction

function automatic predecodeResult modelFullWidth(logic [31:0] w);
  predecodeResult r;
  logic legal;
  logic [2:0] f3;
  f3 = w[14:12];
  case (w[6:0])
    7'h03: legal = f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    7'h23: legal = f3 inside {3'b000, 3'b001, 3'b010};
    7'h63: legal = !(f3 inside {3'b010, 3'b011});
    7'h67: legal = (f3 == 3'b000);
    7'h0F, 7'h13, 7'h17, 7'h33, 7'h37, 7'h6F, 7'h73: legal = 1'b1;
    default: legal = 1'b0;
  endcase
  legal = legal && (w[4:2] != 3'b111);
  r.compressed = 1'b0;
  r.status = legal ? statusOk : statusIllegal;
  r.instruction = legal ? w : '0;
  return r;
endfunction

function automatic predecodeResult expectResult(logic [31:0] w);
  if (w[1:0] == 2'b11) begin
    return modelFullWidth(w);
  end
  return modelCompressed(w[15:0]);
endfunction

`endif

//--- tests/predecoderTb.sv
`timescale 1ns/1ps

`include "predecode_params.svh"

module predecoderTb;
  import predecodePkg::*;

  `include "expandModel.svh"

  localparam int clockPeriod = 40;
  localparam int drainTimeout = 20;
  localparam int randomWords = 300;

  localparam logic [15:0] directedHalfwords [22] = '{
    16'h0000, 16'h0004, 16'h8000, 16'h2000,  // Zero, ADDI4SPN zero imm, reserved, FLD
    16'h0001, 16'h6101, 16'h6081, 16'h4002,  // NOP, zero ADDI16SP, zero LUI, LWSP x0
    16'h8002, 16'h8082, 16'h808A, 16'h9002,  // JR x0, JR, MV, EBREAK
    16'h9082, 16'h908A, 16'h8C89, 16'h8CA9,  // JALR, ADD, SUB, XOR
    16'h8CC9, 16'h8CE9, 16'h9C89, 16'h9CA9,  // OR, AND, SUBW, ADDW
    16'h9CC9, 16'h9CE9                       // Reserved arithmetic
  };

  localparam logic [6:0] opcodeSamples [14] = '{
    7'h03, 7'h0F, 7'h13, 7'h17, 7'h23, 7'h33, 7'h37,
    7'h63, 7'h67, 7'h6F, 7'h73, 7'h07, 7'h5B, 7'h7F  // Last three not RV32I
  };

  logic clock;
  logic reset;
  fetchWord fetch;
  predecodeResult result;
  logic decodeValid;

  predecodeResult expectQueue[$];
  predecodeResult expectedNow;
  logic validLast = 1'b0;
  logic seenValid = 1'b0;
  int mismatchCount = 0;
  int otherErrors = 0;
  int resultCount = 0;
  int sentCount = 0;

  instructionPredecoder dut_i (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .result      (result),
    .decodeValid (decodeValid)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // Expectation moves along with the DUT register
  always @(posedge clock) begin
    validLast <= reset ? 1'b0 : fetch.valid;
    if (!reset && decodeValid) begin
      resultCount++;
    end
    if (!reset && fetch.valid) begin
      seenValid <= 1'b1;
      expectedNow <= expectQueue.pop_front();
    end
  end

  instructionCheck: assert property (@(posedge clock) disable iff (reset)
    decodeValid |-> result.instruction == expectedNow.instruction)
    else begin
      mismatchCount++;
      $display("Mismatch at %0t: result.instruction expected %h, got %h", $time,
               $sampled(expectedNow.instruction), $sampled(result.instruction));
    end

  statusCheck: assert property (@(posedge clock) disable iff (reset)
    decodeValid |-> result.status == expectedNow.status)
    else begin
      mismatchCount++;
      $display("Mismatch at %0t: result.status expected %0d, got %0d", $time,
               $sampled(expectedNow.status), $sampled(result.status));
    end

  compressedCheck: assert property (@(posedge clock) disable iff (reset)
    decodeValid |-> result.compressed == expectedNow.compressed)
    else begin
      mismatchCount++;
      $display("Mismatch at %0t: result.compressed expected %b, got %b", $time,
               $sampled(expectedNow.compressed), $sampled(result.compressed));
    end

  validCheck: assert property (@(posedge clock) disable iff (reset)
    decodeValid == validLast)
    else begin
      mismatchCount++;
      $display("Mismatch at %0t: decodeValid expected %b, got %b", $time,
               $sampled(validLast), $sampled(decodeValid));
    end

  idleResultCheck: assert property (@(posedge clock) disable iff (reset)
    !seenValid |-> result == '0)
    else begin
      mismatchCount++;
      $display("Mismatch at %0t: result expected %h, got %h", $time,
               35'h0, $sampled(result));
    end

  // Last result stays put through idle cycles
  holdCheck: assert property (@(posedge clock) disable iff (reset)
    seenValid && !decodeValid |-> result == expectedNow)
    else begin
      mismatchCount++;
      $display("Mismatch at %0t: result expected %h, got %h", $time,
               $sampled(expectedNow), $sampled(result));
    end

  task automatic sendWord(input logic [31:0] word);
    @(negedge clock);
    fetch.word = word;
    fetch.valid = 1'b1;
    expectQueue.push_back(expectResult(word));
    sentCount++;
  endtask

  task automatic sendCompressed(input logic [15:0] half);
    logic [31:0] noise;
    noise = $urandom;
    sendWord({noise[31:16], half});  // Upper half is ignored
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(negedge clock);
      fetch.valid = 1'b0;
      fetch.word = $urandom;
    end
  endtask

  initial begin
    logic [31:0] word;
    void'($urandom(32'hce6724b5));
    reset = 1'b1;
    fetch = '0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    idleCycles(3);

    foreach (directedHalfwords[i]) begin
      sendCompressed(directedHalfwords[i]);
    end
    idleCycles(2);

    // Every quadrant and funct3 slot, random fields
    for (int q = 0; q < 3; q++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        repeat (6) begin
          word = $urandom;
          sendCompressed({f3[2:0], word[12:2], q[1:0]});
        end
        idleCycles(f3 % 2);
      end
    end

    foreach (opcodeSamples[i]) begin
      repeat (4) begin
        word = $urandom;
        sendWord({word[31:7], opcodeSamples[i]});
      end
    end
    idleCycles(1);

    for (int n = 0; n < randomWords; n++) begin
      sendWord($urandom);
      if ($urandom_range(3) == 0) begin
        idleCycles($urandom_range(3, 1));
      end
    end
    idleCycles(1);

    for (int t = 0; t < drainTimeout && resultCount < sentCount; t++) begin
      @(negedge clock);
    end
    if (resultCount != sentCount) begin
      otherErrors++;
      $display("Decode gave %0d results for %0d fetched words", resultCount, sentCount);
    end

    $display("Results: %0d, mismatches: %0d, other errors: %0d",
             resultCount, mismatchCount, otherErrors);
    if (mismatchCount + otherErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
